// ==== diag_stim.txt ====
# diag_top stimulus: F lines len gap | V | S marker_found resync_used lock_latched | I cycles
# E page value(hex): expected sample, consecutive E lines are checked as one group
F 6 8 4
V
F 9 10 5
V
F 7 12 3
V
F 5 6 2
F 8 10 6
I 8
E 0 0008
E 1 0081
E 2 0000
E 3 0005
E 4 0003
E 5 0002
E 6 0009
V
I 4
V
I 8
E 4 0005
E 5 0000
E 6 0001
S 0 1 0
I 10
S 1 0 0
I 8
E 6 0015
F 4 5 2
V
I 8
E 3 0006
E 5 0000
E 6 0001
S 0 1 0
I 6
S 1 0 1
I 4
E 0 0004
E 6 0003

// ==== flist.f ====
+incdir+.
diag_pkg.sv
field_timing_meter.sv
frame_sync_monitor.sv
diag_pager.sv
diag_top.sv
tb_diag_top.sv

// ==== Makefile ====
# Verilator build and run of the diag_top testbench

sim:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_diag_top
	./obj_dir/Vtb_diag_top | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== tb_diag_top.sv ====
// tb_diag_top testbench: stim file driver, logger model with random busy, sample checks
`timescale 1ns/100ps
`include "diag_config.svh"

module tb_diag_top;
    import diag_pkg::*;

    logic          cam1_pclk;
    logic          cam_resetn;
    logic          cam_line_valid;
    logic          cam_field_toggle;
    logic          hdmi_vsync_toggle;
    align_status_t align_status;
    logic          log_busy = 1'b0;
    logic          log_valid;
    diag_sample_t  log_sample;

    byte         cmd_q[$];
    int          arg_a[$];
    int          arg_b[$];
    int          arg_c[$];
    int          exp_page[$];
    int          exp_value[$];
    int          value_errors = 0;
    int          other_errors = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;
    int          last_lines = 0;
    int          last_period = 0;
    bit          period_known = 0;
    bit          prev_field = 0;
    int          next_page = 0;
    int          since_last = 0;
    int          busy_delay = 0;
    int          busy_left = 0;
    int          sample_count = 0;
    logic [31:0] rng = 32'hcb2;

    diag_top diag_top_inst (
        .cam1_pclk         (cam1_pclk),
        .cam_resetn        (cam_resetn),
        .cam_line_valid    (cam_line_valid),
        .cam_field_toggle  (cam_field_toggle),
        .hdmi_vsync_toggle (hdmi_vsync_toggle),
        .align_status      (align_status),
        .log_busy          (log_busy),
        .log_valid         (log_valid),
        .log_sample        (log_sample)
    );

    initial begin
        cam1_pclk = 1'b0;
        forever #50 cam1_pclk = ~cam1_pclk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("FAILED at time %0t: %s expected 0x%0h, actual 0x%0h",
                     $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic load_stim();
        int    fd;
        int    a;
        int    b;
        int    d;
        byte   c;
        bit    in_group;
        string line;
        cycle_limit = 4 + 2 * `DIAG_PAGES * (`DIAG_INTERVAL_CLKS + 40);
        in_group = 0;
        fd = $fopen("diag_stim.txt", "r");
        if (fd == 0) begin
            $display("ERROR: the stimulus file diag_stim.txt could not be opened");
            other_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                a = 0;
                b = 0;
                d = 0;
                c = line[0];
                if (line.len() > 1 && c != "#") begin
                    if (c == "E") begin
                        void'($sscanf(line.substr(1, line.len() - 1), "%d %h", a, b));
                        if (!in_group) begin
                            cycle_limit += 2 * `DIAG_PAGES * (`DIAG_INTERVAL_CLKS + 40) + 2;
                        end
                    end else if (c != "V") begin
                        void'($sscanf(line.substr(1, line.len() - 1), "%d %d %d", a, b, d));
                    end
                    if (c == "F") cycle_limit += a * (b + d) + 1;
                    else if (c == "I") cycle_limit += a;
                    else cycle_limit += 1;
                    in_group = (c == "E");
                    cmd_q.push_back(c);
                    arg_a.push_back(a);
                    arg_b.push_back(b);
                    arg_c.push_back(d);
                end
            end
            $fclose(fd);
        end
    endtask

    // each line is high for len cycles, then low for gap cycles
    task automatic run_field(input int lines, input int len, input int gap);
        int k;
        for (k = 0; k < lines; k++) begin
            cam_line_valid <= 1'b1;
            repeat (len) @(posedge cam1_pclk);
            cam_line_valid <= 1'b0;
            repeat (gap) @(posedge cam1_pclk);
        end
        cam_field_toggle <= ~cam_field_toggle;
        @(posedge cam1_pclk);
    endtask

    task automatic run_command(input byte c, input int a, input int b, input int d);
        case (c)
            "F": begin
                period_known = prev_field;   // a field directly after a field has a known period
                last_period  = a * (b + d) + 1;
                last_lines   = a;
                run_field(a, b, d);
            end
            "V": begin
                hdmi_vsync_toggle <= ~hdmi_vsync_toggle;
                @(posedge cam1_pclk);
            end
            "S": begin
                align_status.marker_found <= a[0];
                align_status.resync_used  <= b[0];
                align_status.lock_latched <= d[0];
                @(posedge cam1_pclk);
            end
            "I": repeat (a) @(posedge cam1_pclk);
            default: begin
                $display("ERROR: unknown stimulus command '%c'", c);
                other_errors++;
            end
        endcase
        prev_field = (c == "F");
    endtask

    // the file's own numbers for the last field must agree with what it describes
    task automatic check_stim_expect(input int page, input int value);
        if (page == 0) begin
            check_value("stim lines_last", last_lines, value);
        end else if ((page == 1 || page == 2) && !period_known) begin
            $display("ERROR: the stim file expects a period for a field without a known period");
            other_errors++;
        end else if (page == 1) begin
            check_value("stim period_last[15:0]", last_period & 16'hffff, value);
        end else if (page == 2) begin
            check_value("stim period_last[31:16]", last_period >>> 16, value);
        end
    endtask

    // logger model, samples are taken on the edge that ends the valid cycle
    always @(posedge cam1_pclk) begin
        if (log_valid && log_busy) begin
            $display("ERROR at time %0t: a sample was offered while the logger was busy", $time);
            other_errors++;
        end
        if (log_valid) begin
            check_value("log_sample.page", next_page, log_sample.page);
            if (sample_count != 0 && since_last < `DIAG_INTERVAL_CLKS) begin
                $display("ERROR at time %0t: two samples only %0d cycles apart", $time, since_last);
                other_errors++;
            end
            if (exp_page.size() != 0 && exp_page[0] == int'(log_sample.page)) begin
                check_value($sformatf("log_sample.value (page %0d)", exp_page[0]),
                            exp_value[0], log_sample.value);
                void'(exp_page.pop_front());
                void'(exp_value.pop_front());
            end
            next_page = (next_page + 1) % `DIAG_PAGES;
            sample_count++;
            since_last = 1;
            rng = xorshift32(rng);
            busy_delay = int'(rng % `DIAG_INTERVAL_CLKS);   // a late busy stalls the next sample
            rng = xorshift32(rng);
            busy_left = 1 + int'(rng % 32'd40);
            log_busy <= (busy_delay == 0);
        end else begin
            since_last++;
            if (busy_delay > 0) begin
                busy_delay--;
                if (busy_delay == 0) begin
                    log_busy <= 1'b1;
                end
            end else if (busy_left > 1) begin
                busy_left--;
            end else begin
                busy_left = 0;
                log_busy <= 1'b0;
            end
        end
    end

    always @(posedge cam1_pclk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("ERROR: the run did not end within %0d cycles and was stopped", cycle_limit);
            $display("samples: %0d, value errors: %0d, other errors: %0d",
                     sample_count, value_errors, other_errors);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        int i;
        cam_resetn        = 1'b0;
        cam_line_valid    = 1'b0;
        cam_field_toggle  = 1'b0;
        hdmi_vsync_toggle = 1'b0;
        align_status      = 3'b100;   // marker found, no resync, not locked
        load_stim();
        repeat (4) @(posedge cam1_pclk);
        cam_resetn <= 1'b1;
        i = 0;
        while (i < cmd_q.size()) begin
            if (cmd_q[i] == "E") begin
                @(negedge cam1_pclk);   // inputs stay steady until the whole group is seen
                while (i < cmd_q.size() && cmd_q[i] == "E") begin
                    check_stim_expect(arg_a[i], arg_b[i]);
                    exp_page.push_back(arg_a[i]);
                    exp_value.push_back(arg_b[i]);
                    i++;
                end
                while (exp_page.size() != 0) @(negedge cam1_pclk);
                @(posedge cam1_pclk);
                prev_field = 0;
            end else begin
                run_command(cmd_q[i], arg_a[i], arg_b[i], arg_c[i]);
                i++;
            end
        end
        $display("samples: %0d, value errors: %0d, other errors: %0d",
                 sample_count, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== diag_top.sv ====
// diag_top module: camera-clock diagnostics top level with meter, sync monitor and pager
`timescale 1ns/100ps

module diag_top (
    input  logic                    cam1_pclk,
    input  logic                    cam_resetn,
    input  logic                    cam_line_valid,
    input  logic                    cam_field_toggle,
    input  logic                    hdmi_vsync_toggle,
    input  diag_pkg::align_status_t align_status,
    input  logic                    log_busy,
    output logic                    log_valid,
    output diag_pkg::diag_sample_t  log_sample
);
    import diag_pkg::*;

    field_meas_t  field_meas;
    sync_counts_t sync_counts;
    lock_status_t lock_status;

    field_timing_meter field_timing_meter_inst (
        .cam1_pclk        (cam1_pclk),
        .cam_resetn       (cam_resetn),
        .cam_line_valid   (cam_line_valid),
        .cam_field_toggle (cam_field_toggle),
        .field_meas       (field_meas)
    );

    // hdmi_vsync_toggle is foreign, the monitor synchronizes it
    frame_sync_monitor frame_sync_monitor_inst (
        .cam1_pclk         (cam1_pclk),
        .cam_resetn        (cam_resetn),
        .cam_field_toggle  (cam_field_toggle),
        .hdmi_vsync_toggle (hdmi_vsync_toggle),
        .align_status      (align_status),
        .sync_counts       (sync_counts),
        .lock_status       (lock_status)
    );

    diag_pager diag_pager_inst (
        .cam1_pclk   (cam1_pclk),
        .cam_resetn  (cam_resetn),
        .field_meas  (field_meas),
        .sync_counts (sync_counts),
        .lock_status (lock_status),
        .log_busy    (log_busy),
        .log_valid   (log_valid),
        .log_sample  (log_sample)
    );

endmodule

// ==== diag_pager.sv ====
// diag_pager module: sample interval timer, page rotation, value select and logger handshake
`timescale 1ns/100ps
`include "diag_config.svh"

module diag_pager (
    input  logic                   cam1_pclk,
    input  logic                   cam_resetn,
    input  diag_pkg::field_meas_t  field_meas,
    input  diag_pkg::sync_counts_t sync_counts,
    input  diag_pkg::lock_status_t lock_status,
    input  logic                   log_busy,
    output logic                   log_valid,
    output diag_pkg::diag_sample_t log_sample
);
    import diag_pkg::*;

    localparam int               CNT_W      = `DIAG_CNT_W;
    localparam int               TIMER_W    = $clog2(`DIAG_INTERVAL_CLKS);
    localparam logic [TIMER_W-1:0] TIMER_LAST = TIMER_W'(`DIAG_INTERVAL_CLKS - 1);
    localparam logic [7:0]       PAGE_LAST  = 8'(`DIAG_PAGES - 1);

    logic [TIMER_W-1:0] timer;
    logic               due;
    logic [7:0]         page_q;
    logic [CNT_W-1:0]   page_value;

    // the timer stands still while a sample waits for the logger
    always_ff @(posedge cam1_pclk or negedge cam_resetn) begin
        if (!cam_resetn) begin
            timer <= '0;
            due   <= 1'b0;
        end else if (due) begin
            if (!log_busy) begin
                due <= 1'b0;   // sample goes out this cycle
            end
        end else if (timer == TIMER_LAST) begin
            timer <= '0;
            due   <= 1'b1;
        end else begin
            timer <= timer + 1'b1;
        end
    end

    assign log_valid = due & ~log_busy;

    always_ff @(posedge cam1_pclk or negedge cam_resetn) begin
        if (!cam_resetn) begin
            page_q <= '0;
        end else if (log_valid) begin
            page_q <= (page_q == PAGE_LAST) ? 8'd0 : page_q + 8'd1;
        end
    end

    always_comb begin
        page_value = '0;
        case (page_q)
            PAGE_LINES:       page_value[`DIAG_LINE_W-1:0] = field_meas.lines_last;
            PAGE_PERIOD_LO:   page_value = field_meas.period_last[CNT_W-1:0];
            PAGE_PERIOD_HI:   page_value = field_meas.period_last[2*CNT_W-1:CNT_W];
            PAGE_SOF_CNT:     page_value = sync_counts.sof_cnt;
            PAGE_VSYNC_CNT:   page_value = sync_counts.vsync_cnt;
            PAGE_SOF_DELTA:   page_value = sync_counts.sof_delta;
            PAGE_LOCK_STATUS: page_value = lock_status;
            default:          page_value = '0;
        endcase
    end

    // values are live, the logger captures them while log_valid is high
    assign log_sample.page  = page_q;
    assign log_sample.value = page_value;

    a_valid_one_cycle: assert property (
        @(posedge cam1_pclk) disable iff (!cam_resetn)
        log_valid |=> !log_valid
    ) else $error("sample offered for more than one cycle");

    a_page_in_range: assert property (
        @(posedge cam1_pclk) disable iff (!cam_resetn)
        page_q <= PAGE_LAST
    ) else $error("page index out of range");

endmodule

// ==== frame_sync_monitor.sv ====
// frame_sync_monitor module: vsync synchronizer, field/vsync counters and sticky lock flags
`timescale 1ns/100ps
`include "diag_config.svh"

module frame_sync_monitor (
    input  logic                   cam1_pclk,
    input  logic                   cam_resetn,
    input  logic                   cam_field_toggle,
    input  logic                   hdmi_vsync_toggle,
    input  diag_pkg::align_status_t align_status,
    output diag_pkg::sync_counts_t  sync_counts,
    output diag_pkg::lock_status_t  lock_status
);
    import diag_pkg::*;

    localparam int STAGES = `DIAG_VSYNC_STAGES;

    logic [STAGES-1:0]      vsync_sync;
    logic                   vsync_edge;
    logic                   field_tog_d;
    logic                   sof_edge;
    logic                   lock_d;
    logic                   lock_rise;
    logic [`DIAG_CNT_W-1:0] sof_cnt;
    logic [`DIAG_CNT_W-1:0] vsync_cnt;
    logic                   lock_lost;
    logic                   frame_miss;
    logic                   resync_seen;

    // toggle from the hdmi pixel domain, only the last stages are safe to compare
    assign vsync_edge = vsync_sync[STAGES-1] ^ vsync_sync[STAGES-2];
    assign sof_edge   = cam_field_toggle ^ field_tog_d;
    assign lock_rise  = align_status.lock_latched & ~lock_d;

    always_ff @(posedge cam1_pclk or negedge cam_resetn) begin
        if (!cam_resetn) begin
            vsync_sync  <= '0;
            field_tog_d <= 1'b0;
            lock_d      <= 1'b0;
        end else begin
            vsync_sync  <= {vsync_sync[STAGES-2:0], hdmi_vsync_toggle};
            field_tog_d <= cam_field_toggle;
            lock_d      <= align_status.lock_latched;
        end
    end

    always_ff @(posedge cam1_pclk or negedge cam_resetn) begin
        if (!cam_resetn) begin
            sof_cnt   <= '0;
            vsync_cnt <= '0;
        end else begin
            if (sof_edge) begin
                sof_cnt <= sof_cnt + 1'b1;
            end
            if (vsync_edge) begin
                vsync_cnt <= vsync_cnt + 1'b1;
            end
        end
    end

    // flags stay set until an output frame boundary or a fresh lock clears them
    always_ff @(posedge cam1_pclk or negedge cam_resetn) begin
        if (!cam_resetn) begin
            lock_lost   <= 1'b0;
            frame_miss  <= 1'b0;
            resync_seen <= 1'b0;
        end else if (vsync_edge || lock_rise) begin
            lock_lost   <= 1'b0;
            frame_miss  <= 1'b0;
            resync_seen <= 1'b0;
        end else begin
            if (!align_status.marker_found) begin
                lock_lost <= 1'b1;
            end
            if (align_status.resync_used) begin
                resync_seen <= 1'b1;
            end
            if (sof_cnt != vsync_cnt) begin
                frame_miss <= 1'b1;   // input and output frame counts drifted apart
            end
        end
    end

    assign sync_counts.sof_cnt   = sof_cnt;
    assign sync_counts.vsync_cnt = vsync_cnt;
    assign sync_counts.sof_delta = sof_cnt - vsync_cnt;   // wraps modulo the counter width

    assign lock_status.zero         = '0;
    assign lock_status.lock_lost    = lock_lost;
    assign lock_status.frame_miss   = frame_miss;
    assign lock_status.resync_seen  = resync_seen;
    assign lock_status.lock_latched = align_status.lock_latched;
    assign lock_status.marker_found = align_status.marker_found;

    // a new lock must start from a clean flag set
    a_clean_after_lock: assert property (
        @(posedge cam1_pclk) disable iff (!cam_resetn)
        lock_rise |=> !(lock_lost || frame_miss || resync_seen)
    ) else $error("sticky flag set right after lock was latched");

endmodule

// ==== field_timing_meter.sv ====
// field_timing_meter module: lines per field and field period in pixel-clock cycles
`timescale 1ns/100ps
`include "diag_config.svh"

module field_timing_meter (
    input  logic                  cam1_pclk,
    input  logic                  cam_resetn,
    input  logic                  cam_line_valid,
    input  logic                  cam_field_toggle,
    output diag_pkg::field_meas_t field_meas
);
    import diag_pkg::*;

    logic                      field_tog_d;
    logic                      line_valid_d;
    logic                      field_chg;
    logic                      line_rise;
    logic [`DIAG_LINE_W-1:0]   line_cnt;
    logic [`DIAG_PERIOD_W-1:0] cycle_cnt;
    field_meas_t               meas_q;

    assign field_chg = cam_field_toggle ^ field_tog_d;   // a new field starts this cycle
    assign line_rise = cam_line_valid & ~line_valid_d;

    always_ff @(posedge cam1_pclk or negedge cam_resetn) begin
        if (!cam_resetn) begin
            field_tog_d  <= 1'b0;
            line_valid_d <= 1'b0;
        end else begin
            field_tog_d  <= cam_field_toggle;
            line_valid_d <= cam_line_valid;
        end
    end

    // a line that starts in the detection cycle already belongs to the new field
    always_ff @(posedge cam1_pclk or negedge cam_resetn) begin
        if (!cam_resetn) begin
            line_cnt <= '0;
        end else if (field_chg) begin
            line_cnt <= line_rise ? `DIAG_LINE_W'(1) : '0;
        end else if (line_rise) begin
            line_cnt <= line_cnt + 1'b1;
        end
    end

    always_ff @(posedge cam1_pclk or negedge cam_resetn) begin
        if (!cam_resetn) begin
            cycle_cnt <= '0;
        end else if (field_chg) begin
            cycle_cnt <= `DIAG_PERIOD_W'(1);   // the detection cycle opens the next period
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    always_ff @(posedge cam1_pclk or negedge cam_resetn) begin
        if (!cam_resetn) begin
            meas_q <= '0;
        end else if (field_chg) begin
            meas_q.lines_last  <= line_cnt;
            meas_q.period_last <= cycle_cnt;
        end
    end

    assign field_meas = meas_q;

    // a field with more lines than the counter holds would report a bogus count
    a_line_cnt_no_wrap: assert property (
        @(posedge cam1_pclk) disable iff (!cam_resetn)
        (line_rise && !field_chg) |-> (line_cnt != '1)
    ) else $error("line count wrapped inside one field");

endmodule

// ==== diag_pkg.sv ====
// diag_pkg package: alignment and lock status words, field and sync records, sample and pages
`include "diag_config.svh"

package diag_pkg;

    // status bits coming from the alignment logic of the video path
    typedef struct packed {
        logic marker_found;
        logic resync_used;
        logic lock_latched;
    } align_status_t;

    // 16-bit lock word as the logger shows it
    typedef struct packed {
        logic [10:0] zero;
        logic        lock_lost;
        logic        frame_miss;
        logic        resync_seen;
        logic        lock_latched;
        logic        marker_found;
    } lock_status_t;

    typedef struct packed {
        logic [`DIAG_LINE_W-1:0]   lines_last;
        logic [`DIAG_PERIOD_W-1:0] period_last;
    } field_meas_t;

    typedef struct packed {
        logic [`DIAG_CNT_W-1:0] sof_cnt;
        logic [`DIAG_CNT_W-1:0] vsync_cnt;
        logic [`DIAG_CNT_W-1:0] sof_delta;
    } sync_counts_t;

    typedef struct packed {
        logic [7:0]             page;
        logic [`DIAG_CNT_W-1:0] value;
    } diag_sample_t;

    typedef enum logic [7:0] {
        PAGE_LINES       = 8'd0,
        PAGE_PERIOD_LO   = 8'd1,
        PAGE_PERIOD_HI   = 8'd2,
        PAGE_SOF_CNT     = 8'd3,
        PAGE_VSYNC_CNT   = 8'd4,
        PAGE_SOF_DELTA   = 8'd5,
        PAGE_LOCK_STATUS = 8'd6
    } diag_page_e;

endpackage

// ==== diag_config.svh ====
// diagnostic widths, page count, sample interval and vsync synchronizer depth
`ifndef DIAG_CONFIG_SVH
`define DIAG_CONFIG_SVH

// width of the lines-per-field count
`define DIAG_LINE_W 10

// width of the field period, in pixel-clock cycles
`define DIAG_PERIOD_W 32

// counters and page values share this width
`define DIAG_CNT_W 16

// the pager rotates through this many pages
`define DIAG_PAGES 7

// pixel-clock cycles between two sample opportunities
`define DIAG_INTERVAL_CLKS 64

// two metastability stages plus the edge stage
`define DIAG_VSYNC_STAGES 3

`endif
